// File: sources.f
hw/busPkg.sv
hw/cachePkg.sv
hw/dcacheArray.sv
hw/dcacheCtrl.sv
hw/dcache.sv
dv/dcache_checker.sv
dv/dcacheTb.sv

// File: dv/dcacheTb.sv
`timescale 1ns/1ns

module dcacheTb
  import busPkg::*;
();

  logic CLK, nRST, dmemREN, dmemWEN, flush, dWait, ccWait, ccWrite, ccInv;
  logic dhit, halt, dREN, dWEN, snoopable;
  logic [ADDR_W-1:0] dmemAddr, dAddr, ccSnoopAddr;
  logic [WORD_W-1:0] dmemStore, dmemLoad, dStore, dLoad;

  logic [WORD_W-1:0] mem [logic [ADDR_W-1:0]];
  logic [WORD_W-1:0] refMem [logic [ADDR_W-1:0]];
  logic [ADDR_W-1:0] storedAddrs[$], opAddr[$], flushAddrs[$];
  logic [WORD_W-1:0] opData[$];
  bit opWrite[$];
  integer seed = 32'h1a86_13c2;
  int waitLeft, readCount, cycles, rot;
  bit flushActive;
  string testName;
  logic [WORD_W-1:0] rd;
  int waited, reads0;

  dcache #(.nSets(16)) UUT (.*);

  bind dcache dcache_checker chk (.CLK, .nRST, .dREN, .dWEN, .dWait, .dhit, .halt,
    .dAddr, .dStore, .state(ctrl.state));

  initial begin
    CLK = 0;
    forever #20 CLK = ~CLK;
  end

  task automatic failRun(input string what);
    $display("%s", what);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic checkEq(input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else
      failRun($sformatf("ERROR %s: expected %h actual %h", testName, exp, act));
  endtask

  task automatic checkTrue(input bit cond, input string what);
    assert (cond) else failRun($sformatf("%s: %s", testName, what));
  endtask

  // unwritten memory reads back a pattern built from the whole address
  function automatic logic [31:0] pattern(input logic [31:0] a);
    return a ^ 32'h5a5a_0000 ^ {a[15:0], a[31:16]};
  endfunction

  function automatic logic [31:0] refWord(input logic [31:0] a);
    return refMem.exists(a) ? refMem[a] : pattern(a);
  endfunction

  always @(posedge CLK) begin
    cycles++;
    if (cycles == 4000) failRun("TIMEOUT: the run did not finish within 4000 cycles");
  end

  // memory model, 1 to 3 wait cycles per word
  always @(posedge CLK) begin
    #5;
    if (nRST && (dREN || dWEN)) begin
      if (waitLeft > 0) begin
        dWait = 1;
        waitLeft--;
      end else begin
        dWait = 0;
        opWrite.push_back(dWEN);
        opAddr.push_back(dAddr);
        if (dWEN) begin
          mem[dAddr] = dStore;
          opData.push_back(dStore);
        end else begin
          dLoad = mem.exists(dAddr) ? mem[dAddr] : pattern(dAddr);
          opData.push_back(dLoad);
          readCount++;
        end
        waitLeft = 1 + ($unsigned($random(seed)) % 3);
      end
    end else begin
      dWait = 1;
    end
  end

  // bus side during flush, grants only while snoopable and rotates over dirty blocks
  always @(posedge CLK) begin
    #5;
    if (flushActive && flushAddrs.size() > 0) begin
      ccWait = snoopable;
      ccSnoopAddr = flushAddrs[rot];
      rot = (rot + 1) % flushAddrs.size();
    end
  end

  task automatic access(input bit wr, input logic [31:0] addr, input logic [31:0] data);
    waited = 0;
    dmemREN = !wr;
    dmemWEN = wr;
    dmemAddr = addr;
    dmemStore = data;
    @(negedge CLK);
    while (!dhit) begin
      waited++;
      @(negedge CLK);
    end
    rd = dmemLoad;
    @(posedge CLK);
    #5;
    dmemREN = 0;
    dmemWEN = 0;
    if (wr) begin
      refMem[addr] = data;
      storedAddrs.push_back(addr);
    end
  endtask

  task automatic clearOps();
    opWrite.delete();
    opAddr.delete();
    opData.delete();
  endtask

  task automatic checkOp(input int i, input bit w, input logic [31:0] a, input logic [31:0] d);
    checkTrue(opAddr.size() > i, "missing memory transfer");
    checkEq({31'b0, w}, {31'b0, opWrite[i]});
    checkEq(a, opAddr[i]);
    checkEq(d, opData[i]);
  endtask

  initial begin
    {nRST, dmemREN, dmemWEN, flush, ccWait, ccWrite, ccInv} = '0;
    dmemAddr = '0;
    dmemStore = '0;
    ccSnoopAddr = '0;
    dLoad = '0;
    dWait = 1;
    waitLeft = 1 + ($unsigned($random(seed)) % 3);
    repeat (2) @(posedge CLK);
    #5 nRST = 1;

    testName = "reset";
    checkTrue(!dREN && !dWEN && !halt && !snoopable, "outputs not idle after reset");

    testName = "readMiss";
    access(0, 32'h100, 0);
    checkEq(2, readCount);  // first load went to memory
    checkEq(pattern(32'h100), rd);
    reads0 = readCount;
    access(0, 32'h104, 0);
    checkEq(pattern(32'h104), rd);
    checkTrue(waited == 0 && readCount == reads0, "second word did not hit");

    testName = "dirtyEvict";
    access(1, 32'h108, 32'hdead_beef);
    clearOps();
    access(0, 32'h188, 0);  // same index 1, new tag
    checkOp(0, 1, 32'h108, refWord(32'h108));
    checkOp(1, 1, 32'h10c, refWord(32'h10c));
    checkOp(2, 0, 32'h188, pattern(32'h188));
    checkOp(3, 0, 32'h18c, pattern(32'h18c));

    testName = "snoop";
    access(1, 32'h210, 32'h1234_5678);
    clearOps();
    ccSnoopAddr = 32'h210;
    {ccWait, ccWrite, ccInv} = 3'b111;
    @(negedge CLK);
    while (opAddr.size() < 2 || dWEN) @(negedge CLK);
    @(posedge CLK);
    #5 {ccWait, ccWrite, ccInv} = 3'b000;
    checkOp(0, 1, 32'h210, refWord(32'h210));
    checkOp(1, 1, 32'h214, refWord(32'h214));
    reads0 = readCount;
    access(0, 32'h210, 0);
    checkTrue(readCount == reads0 + 2, "invalidated block did not miss");
    checkEq(refWord(32'h210), rd);

    testName = "flush";
    access(1, 32'h320, 32'h0bad_cafe);
    access(1, 32'h334, 32'h7777_0001);
    access(1, 32'h3c8, 32'h8888_0002);
    flushAddrs = '{32'h320, 32'h330, 32'h3c8};
    clearOps();
    flushActive = 1;
    flush = 1;
    @(negedge CLK);
    while (!halt) @(negedge CLK);
    checkEq(6, opAddr.size());  // three dirty blocks
    foreach (storedAddrs[i]) begin
      checkTrue(mem.exists(storedAddrs[i]), "stored word never reached memory");
      checkEq(refMem[storedAddrs[i]], mem[storedAddrs[i]]);
    end

    $display("All tests passed");
    $finish;
  end

endmodule

// File: dv/dcache_checker.sv
`timescale 1ns/1ns

module dcache_checker
  import busPkg::*;
  import cachePkg::*;
(
  input logic              CLK,
  input logic              nRST,
  input logic              dREN,
  input logic              dWEN,
  input logic              dWait,
  input logic              dhit,
  input logic              halt,
  input logic [ADDR_W-1:0] dAddr,
  input logic [WORD_W-1:0] dStore,
  input cacheState_t       state
);

  memReq_t req;

  assign req = memReq_t'({dWEN, dREN});  // read is 01, write is 10

  noBothReq: assert property (@(posedge CLK) disable iff (!nRST)
    req inside {MEM_IDLE, MEM_READ, MEM_WRITE})
    else $error("dREN and dWEN high together");

  haltSticky: assert property (@(posedge CLK) disable iff (!nRST)
    halt |=> halt && state == HALT)
    else $error("halt dropped");

  // read data path refills each cycle, so only the address holds for reads
  readHold: assert property (@(posedge CLK) disable iff (!nRST)
    dWait && dREN |=> $stable(dAddr))
    else $error("dAddr moved during read wait");

  writeHold: assert property (@(posedge CLK) disable iff (!nRST)
    dWait && dWEN |=> $stable(dAddr) && $stable(dStore))
    else $error("dAddr or dStore moved during write wait");

  hitNoMem: assert property (@(posedge CLK) disable iff (!nRST)
    dhit |-> !dREN && !dWEN)
    else $error("dhit during memory request");

endmodule

// File: hw/dcache.sv
`timescale 1ns/1ns

module dcache
  import busPkg::*;
  import cachePkg::*;
#(
  parameter int nSets = 16
) (
  input  logic              CLK,
  input  logic              nRST,
  // datapath
  input  logic              dmemREN,
  input  logic              dmemWEN,
  input  logic              flush,
  input  logic [ADDR_W-1:0] dmemAddr,
  input  logic [WORD_W-1:0] dmemStore,
  output logic              dhit,
  output logic              halt,
  output logic [WORD_W-1:0] dmemLoad,
  // memory
  output logic              dREN,
  output logic              dWEN,
  output logic [ADDR_W-1:0] dAddr,
  output logic [WORD_W-1:0] dStore,
  input  logic [WORD_W-1:0] dLoad,
  input  logic              dWait,
  // coherence
  input  logic              ccWait,
  input  logic              ccWrite,
  input  logic              ccInv,
  input  logic [ADDR_W-1:0] ccSnoopAddr,
  output logic              snoopable
);

  logic        miss;
  logic        victimDirty;
  logic        snoopDirtyHit;
  logic        sameAddr;
  logic        flushDone;
  cacheState_t srcSel;
  logic        blockOffset;
  logic        fillWord;
  logic        fillDone;
  logic        invalidate;
  logic        flctUp;

  dcacheArray #(
    .nSets(nSets)
  ) cacheArray (
    .CLK(CLK),
    .nRST(nRST),
    .dmemREN(dmemREN),
    .dmemWEN(dmemWEN),
    .dmemAddr(dmemAddr),
    .dmemStore(dmemStore),
    .dhit(dhit),
    .dmemLoad(dmemLoad),
    .ccSnoopAddr(ccSnoopAddr),
    .dLoad(dLoad),
    .dAddr(dAddr),
    .dStore(dStore),
    .srcSel(srcSel),
    .blockOffset(blockOffset),
    .fillWord(fillWord),
    .fillDone(fillDone),
    .invalidate(invalidate),
    .flctUp(flctUp),
    .miss(miss),
    .victimDirty(victimDirty),
    .snoopDirtyHit(snoopDirtyHit),
    .sameAddr(sameAddr),
    .flushDone(flushDone)
  );

  dcacheCtrl ctrl (
    .CLK(CLK),
    .nRST(nRST),
    .miss(miss),
    .victimDirty(victimDirty),
    .snoopDirtyHit(snoopDirtyHit),
    .sameAddr(sameAddr),
    .flushDone(flushDone),
    .flush(flush),
    .halt(halt),
    .dWait(dWait),
    .dREN(dREN),
    .dWEN(dWEN),
    .ccWait(ccWait),
    .ccWrite(ccWrite),
    .ccInv(ccInv),
    .snoopable(snoopable),
    .srcSel(srcSel),
    .blockOffset(blockOffset),
    .fillWord(fillWord),
    .fillDone(fillDone),
    .invalidate(invalidate),
    .flctUp(flctUp)
  );

endmodule

// File: hw/dcacheCtrl.sv
`timescale 1ns/1ns

module dcacheCtrl
  import busPkg::*;
  import cachePkg::*;
(
  input  logic        CLK,
  input  logic        nRST,
  // array status
  input  logic        miss,
  input  logic        victimDirty,
  input  logic        snoopDirtyHit,
  input  logic        sameAddr,
  input  logic        flushDone,
  // datapath
  input  logic        flush,
  output logic        halt,
  // memory
  input  logic        dWait,
  output logic        dREN,
  output logic        dWEN,
  // coherence
  input  logic        ccWait,
  input  logic        ccWrite,
  input  logic        ccInv,
  output logic        snoopable,
  // array control
  output cacheState_t srcSel,
  output logic        blockOffset,
  output logic        fillWord,
  output logic        fillDone,
  output logic        invalidate,
  output logic        flctUp
);

  cacheState_t state;
  cacheState_t nextState;
  memReq_t     memReq;
  logic        snoopReq;

  assign snoopReq = ccWait & ccWrite & snoopDirtyHit;

  assign dREN   = (memReq == MEM_READ);
  assign dWEN   = (memReq == MEM_WRITE);
  assign srcSel = state;

  always_comb begin
    memReq      = MEM_IDLE;
    blockOffset = 1'b0;
    fillWord    = 1'b0;
    fillDone    = 1'b0;
    invalidate  = 1'b0;
    flctUp      = 1'b0;
    snoopable   = 1'b0;
    halt        = 1'b0;
    case (state)
      WB1: memReq = MEM_WRITE;
      WB2: begin
        memReq      = MEM_WRITE;
        blockOffset = 1'b1;
      end
      SNP1: memReq = MEM_WRITE;
      SNP2: begin
        memReq      = MEM_WRITE;
        blockOffset = 1'b1;
        invalidate  = ccInv;
      end
      READ1: begin
        memReq   = MEM_READ;
        fillWord = 1'b1;
      end
      READ2: begin
        memReq      = MEM_READ;
        blockOffset = 1'b1;
        fillWord    = 1'b1;
        fillDone    = 1'b1;
      end
      FLSTART: snoopable = 1'b1;
      FLPRE:   snoopable = 1'b1;   // waiting for the bus to point at our block
      FLUSH1:  memReq = MEM_WRITE;
      FLUSH2: begin
        memReq      = MEM_WRITE;
        blockOffset = 1'b1;
        invalidate  = 1'b1;
      end
      FLCT1: begin
        snoopable = 1'b1;
        flctUp    = 1'b1;
      end
      FLCT2:   flctUp = 1'b1;
      HALT:    halt = 1'b1;
      default: ;
    endcase
  end

  always_comb begin
    nextState = state;
    case (state)
      IDLE: begin
        if (miss && !ccWait) begin
          nextState = victimDirty ? WB1 : READ1;
        end else if (flush) begin
          nextState = FLSTART;
        end else if (snoopReq) begin
          nextState = SNP1;
        end
      end
      WB1:   if (!dWait) nextState = WB2;
      WB2:   if (!dWait) nextState = READ1;
      SNP1:  if (!dWait) nextState = SNP2;
      SNP2:  if (!dWait) nextState = IDLE;
      READ1: if (!dWait) nextState = READ2;
      READ2: if (!dWait) nextState = IDLE;
      FLSTART: begin
        if (flushDone) begin
          nextState = HALT;
        end else begin
          nextState = victimDirty ? FLPRE : FLCT1;
        end
      end
      FLPRE:   if (sameAddr && ccWait) nextState = FLUSH1;
      FLUSH1:  if (!dWait) nextState = FLUSH2;
      FLUSH2:  if (!dWait) nextState = FLCT2;
      FLCT1:   nextState = FLSTART;
      FLCT2:   nextState = FLSTART;
      HALT:    nextState = HALT;  // only reset leaves
      default: nextState = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

endmodule

// File: hw/dcacheArray.sv
`timescale 1ns/1ns

module dcacheArray
  import busPkg::*;
  import cachePkg::*;
#(
  parameter int nSets = 16
) (
  input  logic              CLK,
  input  logic              nRST,
  // datapath
  input  logic              dmemREN,
  input  logic              dmemWEN,
  input  logic [ADDR_W-1:0] dmemAddr,
  input  logic [WORD_W-1:0] dmemStore,
  output logic              dhit,
  output logic [WORD_W-1:0] dmemLoad,
  // memory and coherence
  input  logic [ADDR_W-1:0] ccSnoopAddr,
  input  logic [WORD_W-1:0] dLoad,
  output logic [ADDR_W-1:0] dAddr,
  output logic [WORD_W-1:0] dStore,
  // from control
  input  cacheState_t       srcSel,
  input  logic              blockOffset,
  input  logic              fillWord,
  input  logic              fillDone,
  input  logic              invalidate,
  input  logic              flctUp,
  // to control
  output logic              miss,
  output logic              victimDirty,
  output logic              snoopDirtyHit,
  output logic              sameAddr,
  output logic              flushDone
);

  localparam int idxW = $clog2(nSets);
  localparam int tagW = ADDR_W - IDX_LSB - idxW;
  localparam int cntW = $clog2(nSets + 1);

  // storage
  logic [tagW-1:0]   tags  [nSets];
  logic [WORD_W-1:0] words [nSets][BLOCK_WORDS];
  logic [nSets-1:0]  valid;
  logic [nSets-1:0]  dirty;
  logic [cntW-1:0]   flct;   // flush walk position, runs to nSets

  // address fields
  logic [idxW-1:0] reqIdx;
  logic [tagW-1:0] reqTag;
  logic            reqOff;
  logic [idxW-1:0] snIdx;
  logic [tagW-1:0] snTag;
  logic [idxW-1:0] flIdx;

  // block that currently faces the memory bus
  logic [idxW-1:0] selIdx;
  logic [tagW-1:0] selTag;

  logic request;
  logic rawHit;
  logic flushing;
  logic snooping;

  assign reqIdx = dmemAddr[IDX_LSB +: idxW];
  assign reqTag = dmemAddr[ADDR_W-1 -: tagW];
  assign reqOff = dmemAddr[BYTE_OFF_W];
  assign snIdx  = ccSnoopAddr[IDX_LSB +: idxW];
  assign snTag  = ccSnoopAddr[ADDR_W-1 -: tagW];
  assign flIdx  = flct[idxW-1:0];

  assign flushing = srcSel inside {FLSTART, FLPRE, FLUSH1, FLUSH2, FLCT1, FLCT2};
  assign snooping = srcSel inside {SNP1, SNP2};

  // lookup
  assign request = dmemREN | dmemWEN;
  assign rawHit  = valid[reqIdx] && (tags[reqIdx] == reqTag);
  assign miss    = request & ~rawHit;
  assign dhit    = request & rawHit & (srcSel == IDLE);  // only answer when control is idle
  assign dmemLoad = words[reqIdx][reqOff];

  always_comb begin
    if (flushing) begin
      selIdx = flIdx;
      selTag = tags[flIdx];
    end else if (snooping) begin
      selIdx = snIdx;
      selTag = snTag;
    end else if (srcSel inside {WB1, WB2}) begin
      selIdx = reqIdx;
      selTag = tags[reqIdx];   // victim keeps its old tag
    end else begin
      selIdx = reqIdx;
      selTag = reqTag;
    end
  end

  assign dAddr  = {selTag, selIdx, blockOffset, {BYTE_OFF_W{1'b0}}};
  assign dStore = words[selIdx][blockOffset];

  // request index in idle, walk index during flush
  assign victimDirty   = valid[selIdx] & dirty[selIdx];
  assign snoopDirtyHit = valid[snIdx] & dirty[snIdx] & (tags[snIdx] == snTag);
  assign sameAddr      = (snIdx == flIdx) && (snTag == tags[flIdx]);
  assign flushDone     = (flct == cntW'(nSets));

  // data and tags
  always_ff @(posedge CLK) begin
    if (dhit && dmemWEN) begin
      words[reqIdx][reqOff] <= dmemStore;
    end
    if (fillWord) begin
      words[reqIdx][blockOffset] <= dLoad;  // rewritten each wait cycle, last one sticks
    end
    if (fillDone) begin
      tags[reqIdx] <= reqTag;
    end
  end

  // block state and walk counter
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
      dirty <= '0;
      flct  <= '0;
    end else begin
      if (dhit && dmemWEN) begin
        dirty[reqIdx] <= 1'b1;
      end
      if (fillDone) begin
        valid[reqIdx] <= 1'b1;
        dirty[reqIdx] <= 1'b0;
      end
      if (srcSel == SNP2) begin
        dirty[selIdx] <= 1'b0;   // written back, clean even if kept
      end
      if (invalidate) begin
        valid[selIdx] <= 1'b0;
        dirty[selIdx] <= 1'b0;
      end
      if (flctUp) begin
        flct <= flct + 1'b1;
      end
    end
  end

endmodule

// File: hw/cachePkg.sv
package cachePkg;

  // two words per block
  localparam int BLOCK_WORDS = 2;

  // address split: tag | index | block offset | byte offset
  localparam int BYTE_OFF_W = 2;
  localparam int BLK_OFF_W = $clog2(BLOCK_WORDS);
  localparam int IDX_LSB = BYTE_OFF_W + BLK_OFF_W;

  typedef enum logic [3:0] {
    IDLE,
    WB1,      // victim word 0
    WB2,      // victim word 1
    SNP1,     // snoop write-back
    SNP2,
    READ1,    // refill
    READ2,
    FLSTART,  // flush walk
    FLPRE,
    FLUSH1,
    FLUSH2,
    FLCT1,
    FLCT2,
    HALT
  } cacheState_t;

endpackage

// File: hw/busPkg.sv
package busPkg;

  // memory side widths
  localparam int WORD_W = 32;
  localparam int ADDR_W = 32;

  // what the cache asks of memory in a given cycle
  typedef enum logic [1:0] {
    MEM_IDLE,
    MEM_READ,
    MEM_WRITE
  } memReq_t;

endpackage
